/* board_ctrl.f */
logic/apb_pkg.sv
logic/board_pkg.sv
logic/debounce_switch.sv
logic/uart_phy.sv
logic/uart_apb_bridge.sv
logic/button_ctrl.sv
logic/apb_arbiter.sv
logic/gpio_regs.sv
logic/fpga_core.sv
test/fpga_core_checker.sv
test/fpga_core_tb.sv

/* logic/apb_arbiter.sv */
// Two master APB arbiter
`timescale 1ns/1ps
`default_nettype none

module apb_arbiter (
    input  wire               clk,
    input  wire               rst_n,
    input  apb_pkg::apb_req_t m0_req,
    output apb_pkg::apb_rsp_t m0_rsp,
    input  apb_pkg::apb_req_t m1_req,
    output apb_pkg::apb_rsp_t m1_rsp,
    output apb_pkg::apb_req_t s_req,
    input  apb_pkg::apb_rsp_t s_rsp
);
    logic busy;
    logic gnt;
    logic s_access;
    logic last;
    logic pick;
    logic done;

    // Both requesting goes to the master not served last
    assign pick = (m0_req.psel && m1_req.psel) ? !last : m1_req.psel;
    assign done = busy && s_access && s_rsp.pready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy     <= 1'b0;
            gnt      <= 1'b0;
            s_access <= 1'b0;
            last     <= 1'b1;
        end else if (!busy) begin
            // New grant only with the slave side idle
            if (m0_req.psel || m1_req.psel) begin
                busy     <= 1'b1;
                gnt      <= pick;
                s_access <= 1'b0;
            end
        end else if (!s_access) begin
            s_access <= 1'b1;
        end else if (done) begin
            busy <= 1'b0;
            last <= gnt;
        end
    end

    // Slave gets its own setup cycle after the grant
    // the master holds off in wait states meanwhile
    always_comb begin
        s_req  = '0;
        m0_rsp = '{pready: 1'b0, pslverr: 1'b0, prdata: s_rsp.prdata};
        m1_rsp = '{pready: 1'b0, pslverr: 1'b0, prdata: s_rsp.prdata};
        if (busy) begin
            s_req         = gnt ? m1_req : m0_req;
            s_req.penable = s_access;
            if (gnt) begin
                m1_rsp.pready  = done;
                m1_rsp.pslverr = s_rsp.pslverr;
            end else begin
                m0_rsp.pready  = done;
                m0_rsp.pslverr = s_rsp.pslverr;
            end
        end
    end

endmodule

`default_nettype wire

/* logic/apb_pkg.sv */
// APB bus definitions
`default_nettype none

package apb_pkg;

    // Bus widths
    localparam int APB_ADDR_W = 8;
    localparam int APB_DATA_W = 8;

    // Master to slave
    typedef struct packed {
        logic                  psel;
        logic                  penable;
        logic                  pwrite;
        logic [APB_ADDR_W-1:0] paddr;
        logic [APB_DATA_W-1:0] pwdata;
    } apb_req_t;

    // Slave to master
    typedef struct packed {
        logic                  pready;
        logic                  pslverr;
        logic [APB_DATA_W-1:0] prdata;
    } apb_rsp_t;

    // Register map of the GPIO block
    localparam logic [APB_ADDR_W-1:0] REG_LED     = 8'd0;
    localparam logic [APB_ADDR_W-1:0] REG_SW      = 8'd1;
    localparam logic [APB_ADDR_W-1:0] REG_BTN     = 8'd2;
    localparam logic [APB_ADDR_W-1:0] REG_SCRATCH = 8'd3;

endpackage

`default_nettype wire

/* logic/board_pkg.sv */
// Board IO definitions
`default_nettype none

package board_pkg;

    // Push buttons, up left down right center
    typedef struct packed {
        logic u;
        logic l;
        logic d;
        logic r;
        logic c;
    } btn_t;

    // Clocks per UART bit, small for simulation
    localparam int UART_DIV = 16;

    // Debounce sample spacing and run length
    localparam int DEBOUNCE_RATE = 4;
    localparam int DEBOUNCE_N    = 3;

    // Host command bytes
    localparam logic [7:0] CMD_WRITE = 8'h57;
    localparam logic [7:0] CMD_READ  = 8'h52;

    // Reply status bytes
    localparam logic [7:0] RSP_OK  = 8'h4B;
    localparam logic [7:0] RSP_ERR = 8'h45;

endpackage

`default_nettype wire

/* logic/button_ctrl.sv */
// Button press to LED register writes
`timescale 1ns/1ps
`default_nettype none

module button_ctrl (
    input  wire               clk,
    input  wire               rst_n,
    input  board_pkg::btn_t   btn,
    input  wire  [7:0]        sw,
    output apb_pkg::apb_req_t apb_req,
    input  apb_pkg::apb_rsp_t apb_rsp
);
    import apb_pkg::*;

    typedef enum logic [1:0] {
        B_IDLE,
        B_SETUP,
        B_ACCESS
    } state_t;

    state_t                state;
    logic                  c_q;
    logic                  l_q;
    logic                  c_pend;
    logic                  l_pend;
    logic [APB_DATA_W-1:0] wdata_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= B_IDLE;
            c_q     <= 1'b0;
            l_q     <= 1'b0;
            c_pend  <= 1'b0;
            l_pend  <= 1'b0;
            wdata_q <= '0;
        end else begin
            c_q <= btn.c;
            l_q <= btn.l;
            case (state)
                B_IDLE: begin
                    // Center press copies the switches, left clears
                    if (c_pend) begin
                        c_pend  <= 1'b0;
                        wdata_q <= sw;
                        state   <= B_SETUP;
                    end else if (l_pend) begin
                        l_pend  <= 1'b0;
                        wdata_q <= '0;
                        state   <= B_SETUP;
                    end
                end
                B_SETUP: state <= B_ACCESS;
                B_ACCESS: begin
                    if (apb_rsp.pready) begin
                        state <= B_IDLE;
                    end
                end
                default: state <= B_IDLE;
            endcase
            // Presses during a write wait here, set wins over clear
            if (btn.c && !c_q) begin
                c_pend <= 1'b1;
            end
            if (btn.l && !l_q) begin
                l_pend <= 1'b1;
            end
        end
    end

    assign apb_req = '{
        psel:    (state != B_IDLE),
        penable: (state == B_ACCESS),
        pwrite:  1'b1,
        paddr:   REG_LED,
        pwdata:  wdata_q
    };

endmodule

`default_nettype wire

/* logic/debounce_switch.sv */
// Switch and button debouncer
`timescale 1ns/1ps
`default_nettype none

module debounce_switch #(
    parameter type payload_t = logic
) (
    input  wire      clk,
    input  wire      rst_n,
    input  payload_t in,
    output payload_t out
);
    import board_pkg::*;

    localparam int W     = $bits(payload_t);
    localparam int CNT_W = $clog2(DEBOUNCE_RATE);

    logic [W-1:0]                  in_meta;
    logic [W-1:0]                  in_sync;
    logic [CNT_W-1:0]              rate_cnt;
    logic                          tick;
    logic [DEBOUNCE_N-1:0][W-1:0]  hist;
    logic [DEBOUNCE_N-1:0][W-1:0]  hist_next;
    logic [W-1:0]                  all_one;
    logic [W-1:0]                  all_zero;
    logic [W-1:0]                  out_q;

    // Sample strobe every DEBOUNCE_RATE clocks
    assign tick = (rate_cnt == CNT_W'(DEBOUNCE_RATE - 1));

    // History with the new sample shifted in, then per bit agreement
    always_comb begin
        hist_next = {hist[DEBOUNCE_N-2:0], in_sync};
        all_one   = '1;
        all_zero  = '1;
        for (int k = 0; k < DEBOUNCE_N; k++) begin
            all_one  = all_one & hist_next[k];
            all_zero = all_zero & ~hist_next[k];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_meta  <= '0;
            in_sync  <= '0;
            rate_cnt <= '0;
            hist     <= '0;
            out_q    <= '0;
        end else begin
            // Two flop synchronizer ahead of the sampler
            in_meta  <= in;
            in_sync  <= in_meta;
            rate_cnt <= tick ? '0 : rate_cnt + 1'b1;
            if (tick) begin
                hist  <= hist_next;
                // Bits with mixed samples keep their old value
                out_q <= (out_q | all_one) & ~all_zero;
            end
        end
    end

    assign out = payload_t'(out_q);

endmodule

`default_nettype wire

/* logic/fpga_core.sv */
// Board control core
`timescale 1ns/1ps
`default_nettype none

module fpga_core (
    input  wire             clk,
    input  wire             rst_n,
    input  board_pkg::btn_t btn,
    input  wire  [7:0]      sw,
    output logic [7:0]      led,
    input  wire             uart_rxd,
    output logic            uart_txd
);
    import apb_pkg::*;
    import board_pkg::*;

    btn_t       btn_int;
    logic [7:0] sw_int;

    logic [7:0] rx_data;
    logic       rx_valid;
    logic [7:0] tx_data;
    logic       tx_valid;
    logic       tx_ready;

    // Bridge on arbiter port 0, buttons on port 1
    apb_req_t   bridge_req;
    apb_rsp_t   bridge_rsp;
    apb_req_t   button_req;
    apb_rsp_t   button_rsp;
    apb_req_t   regs_req;
    apb_rsp_t   regs_rsp;

    // Debounced GPIO inputs
    debounce_switch #(.payload_t(btn_t)) btn_debounce_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .in    (btn),
        .out   (btn_int)
    );

    debounce_switch #(.payload_t(logic [7:0])) sw_debounce_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .in    (sw),
        .out   (sw_int)
    );

    // Host UART, 8N1
    uart_phy uart_phy_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .rxd      (uart_rxd),
        .txd      (uart_txd),
        .rx_data  (rx_data),
        .rx_valid (rx_valid),
        .tx_data  (tx_data),
        .tx_valid (tx_valid),
        .tx_ready (tx_ready)
    );

    uart_apb_bridge uart_apb_bridge_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .rx_data  (rx_data),
        .rx_valid (rx_valid),
        .tx_data  (tx_data),
        .tx_valid (tx_valid),
        .tx_ready (tx_ready),
        .apb_req  (bridge_req),
        .apb_rsp  (bridge_rsp)
    );

    button_ctrl button_ctrl_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .btn     (btn_int),
        .sw      (sw_int),
        .apb_req (button_req),
        .apb_rsp (button_rsp)
    );

    apb_arbiter apb_arbiter_inst (
        .clk    (clk),
        .rst_n  (rst_n),
        .m0_req (bridge_req),
        .m0_rsp (bridge_rsp),
        .m1_req (button_req),
        .m1_rsp (button_rsp),
        .s_req  (regs_req),
        .s_rsp  (regs_rsp)
    );

    gpio_regs gpio_regs_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .apb_req (regs_req),
        .apb_rsp (regs_rsp),
        .sw      (sw_int),
        .btn     (btn_int),
        .led     (led)
    );

endmodule

`default_nettype wire

/* logic/gpio_regs.sv */
// GPIO register block
`timescale 1ns/1ps
`default_nettype none

module gpio_regs (
    input  wire               clk,
    input  wire               rst_n,
    input  apb_pkg::apb_req_t apb_req,
    output apb_pkg::apb_rsp_t apb_rsp,
    input  wire  [7:0]        sw,
    input  board_pkg::btn_t   btn,
    output logic [7:0]        led
);
    import apb_pkg::*;

    logic                  access;
    logic                  rd_err;
    logic [APB_DATA_W-1:0] rd_data;
    logic [APB_DATA_W-1:0] led_q;
    logic [APB_DATA_W-1:0] scratch_q;

    // No wait states
    assign access = apb_req.psel && apb_req.penable;

    // Read mux and error decode
    always_comb begin
        rd_data = '0;
        rd_err  = 1'b0;
        case (apb_req.paddr)
            REG_LED:     rd_data = led_q;
            REG_SW:      rd_data = sw;
            REG_BTN:     rd_data = {3'b000, btn};
            REG_SCRATCH: rd_data = scratch_q;
            default:     rd_err  = 1'b1;
        endcase
        // Status inputs reject writes
        if (apb_req.pwrite && (apb_req.paddr == REG_SW || apb_req.paddr == REG_BTN)) begin
            rd_err = 1'b1;
        end
        if (rd_err) begin
            rd_data = '0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            led_q     <= '0;
            scratch_q <= '0;
        end else if (access && apb_req.pwrite) begin
            if (apb_req.paddr == REG_LED) begin
                led_q <= apb_req.pwdata;
            end
            if (apb_req.paddr == REG_SCRATCH) begin
                scratch_q <= apb_req.pwdata;
            end
        end
    end

    assign apb_rsp = '{pready: access, pslverr: access && rd_err, prdata: rd_data};
    assign led     = led_q;

endmodule

`default_nettype wire

/* logic/uart_apb_bridge.sv */
// UART command to APB bridge
`timescale 1ns/1ps
`default_nettype none

module uart_apb_bridge (
    input  wire               clk,
    input  wire               rst_n,
    input  wire  [7:0]        rx_data,
    input  wire               rx_valid,
    output logic [7:0]        tx_data,
    output logic              tx_valid,
    input  wire               tx_ready,
    output apb_pkg::apb_req_t apb_req,
    input  apb_pkg::apb_rsp_t apb_rsp
);
    import apb_pkg::*;
    import board_pkg::*;

    typedef enum logic [2:0] {
        S_CMD,
        S_ADDR,
        S_WDATA,
        S_SETUP,
        S_ACCESS,
        S_STATUS,
        S_RDATA
    } state_t;

    state_t                state;
    logic                  is_write;
    logic [APB_ADDR_W-1:0] addr_q;
    logic [APB_DATA_W-1:0] wdata_q;
    logic [APB_DATA_W-1:0] rdata_q;
    logic [7:0]            status_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= S_CMD;
            is_write <= 1'b0;
            addr_q   <= '0;
            wdata_q  <= '0;
            rdata_q  <= '0;
            status_q <= '0;
        end else begin
            case (state)
                S_CMD: begin
                    // Unknown command bytes are dropped
                    if (rx_valid && (rx_data == CMD_WRITE || rx_data == CMD_READ)) begin
                        is_write <= (rx_data == CMD_WRITE);
                        state    <= S_ADDR;
                    end
                end
                S_ADDR: begin
                    if (rx_valid) begin
                        addr_q <= rx_data;
                        state  <= is_write ? S_WDATA : S_SETUP;
                    end
                end
                S_WDATA: begin
                    if (rx_valid) begin
                        wdata_q <= rx_data;
                        state   <= S_SETUP;
                    end
                end
                S_SETUP: state <= S_ACCESS;
                S_ACCESS: begin
                    // Wait states while the arbiter serves the other master
                    if (apb_rsp.pready) begin
                        status_q <= apb_rsp.pslverr ? RSP_ERR : RSP_OK;
                        rdata_q  <= apb_rsp.prdata;
                        state    <= S_STATUS;
                    end
                end
                S_STATUS: begin
                    // Data byte only after a good read
                    if (tx_ready) begin
                        state <= (!is_write && status_q == RSP_OK) ? S_RDATA : S_CMD;
                    end
                end
                S_RDATA: begin
                    if (tx_ready) begin
                        state <= S_CMD;
                    end
                end
                default: state <= S_CMD;
            endcase
        end
    end

    assign apb_req = '{
        psel:    (state == S_SETUP) || (state == S_ACCESS),
        penable: (state == S_ACCESS),
        pwrite:  is_write,
        paddr:   addr_q,
        pwdata:  wdata_q
    };

    assign tx_valid = (state == S_STATUS) || (state == S_RDATA);
    assign tx_data  = (state == S_RDATA) ? rdata_q : status_q;

endmodule

`default_nettype wire

/* logic/uart_phy.sv */
// UART 8N1 transceiver
`timescale 1ns/1ps
`default_nettype none

module uart_phy (
    input  wire        clk,
    input  wire        rst_n,
    input  wire        rxd,
    output logic       txd,
    output logic [7:0] rx_data,
    output logic       rx_valid,
    input  wire  [7:0] tx_data,
    input  wire        tx_valid,
    output logic       tx_ready
);
    import board_pkg::*;

    localparam int CNT_W = $clog2(UART_DIV);

    logic             rx_meta;
    logic             rx_sync;
    logic             rx_busy;
    logic [3:0]       rx_bit;
    logic [CNT_W-1:0] rx_cnt;
    logic [7:0]       rx_shift;

    logic             tx_busy;
    logic [3:0]       tx_bit;
    logic [CNT_W-1:0] tx_cnt;
    logic [9:0]       tx_frame;

    // Receiver
    // bit 0 is the start bit, 1 to 8 data, 9 the stop bit
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_meta  <= 1'b1;
            rx_sync  <= 1'b1;
            rx_busy  <= 1'b0;
            rx_bit   <= '0;
            rx_cnt   <= '0;
            rx_shift <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_meta  <= rxd;
            rx_sync  <= rx_meta;
            rx_valid <= 1'b0;
            if (!rx_busy) begin
                // Falling edge on an idle line, wait half a bit
                if (!rx_sync) begin
                    rx_busy <= 1'b1;
                    rx_bit  <= '0;
                    rx_cnt  <= CNT_W'(UART_DIV / 2 - 1);
                end
            end else if (rx_cnt != '0) begin
                rx_cnt <= rx_cnt - 1'b1;
            end else begin
                // Mid-bit sample point
                rx_cnt <= CNT_W'(UART_DIV - 1);
                rx_bit <= rx_bit + 4'd1;
                if (rx_bit == 4'd0) begin
                    // Glitch, not a start bit
                    if (rx_sync) begin
                        rx_busy <= 1'b0;
                    end
                end else if (rx_bit != 4'd9) begin
                    rx_shift <= {rx_sync, rx_shift[7:1]};
                end else begin
                    rx_busy  <= 1'b0;
                    // Framing error drops the byte
                    rx_valid <= rx_sync;
                end
            end
        end
    end

    assign rx_data = rx_shift;

    // Transmitter
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tx_busy  <= 1'b0;
            tx_bit   <= '0;
            tx_cnt   <= '0;
            tx_frame <= '1;
        end else if (!tx_busy) begin
            if (tx_valid) begin
                tx_busy  <= 1'b1;
                tx_bit   <= '0;
                tx_cnt   <= CNT_W'(UART_DIV - 1);
                tx_frame <= {1'b1, tx_data, 1'b0};
            end
        end else if (tx_cnt != '0) begin
            tx_cnt <= tx_cnt - 1'b1;
        end else begin
            // Next bit, idle ones fill from the top
            tx_cnt   <= CNT_W'(UART_DIV - 1);
            tx_frame <= {1'b1, tx_frame[9:1]};
            if (tx_bit == 4'd9) begin
                tx_busy <= 1'b0;
            end else begin
                tx_bit <= tx_bit + 4'd1;
            end
        end
    end

    assign txd      = tx_frame[0];
    assign tx_ready = !tx_busy;

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert \
    --top-module fpga_core_tb \
    -f board_ctrl.f \
    -o fpga_core_sim
./obj_dir/fpga_core_sim

/* test/fpga_core_checker.sv */
// APB and LED assertions
`timescale 1ns/1ps
`default_nettype none

module fpga_core_checker (
    input wire               clk,
    input wire               rst_n,
    input apb_pkg::apb_req_t s_req,
    input apb_pkg::apb_rsp_t s_rsp,
    input apb_pkg::apb_req_t m0_req,
    input apb_pkg::apb_rsp_t m0_rsp,
    input wire [7:0]         led
);
    // Slave side request frozen from setup until pready
    a_slave_hold: assert property (@(posedge clk) disable iff (!rst_n)
        s_req.psel && !s_rsp.pready |=> s_req.psel && $stable(s_req.paddr)
            && $stable(s_req.pwrite) && $stable(s_req.pwdata))
        else $error("slave request changed while waiting for pready");

    // Bridge holds its request through arbiter wait states
    a_bridge_hold: assert property (@(posedge clk) disable iff (!rst_n)
        m0_req.psel && !m0_rsp.pready |=> m0_req.psel && $stable(m0_req.paddr)
            && $stable(m0_req.pwrite) && $stable(m0_req.pwdata))
        else $error("bridge request changed while waiting for pready");

    a_penable_psel: assert property (@(posedge clk) disable iff (!rst_n)
        s_req.penable |-> s_req.psel)
        else $error("penable high without psel");

    // LEDs dark while in reset
    a_led_reset: assert property (@(posedge clk) !rst_n |-> led == 8'h00)
        else $error("led not cleared during reset");

endmodule

`default_nettype wire

/* test/fpga_core_tb.sv */
// Board control core testbench
`timescale 1ns/1ps
`default_nettype none

module fpga_core_tb;
    import apb_pkg::*;
    import board_pkg::*;

    localparam int CLK_PERIOD      = 8;
    localparam int RESET_CYCLES    = 16;
    // Beyond the debounce bound, sync stages included
    localparam int SETTLE_CYCLES   = DEBOUNCE_RATE * (DEBOUNCE_N + 3) + 8;
    localparam int RX_TIMEOUT      = 48 * UART_DIV;
    localparam int LED_TIMEOUT     = 100;
    localparam int WATCHDOG_CYCLES = 100000;
    localparam logic [7:0] CMD_UNKNOWN = 8'h3C;
    localparam btn_t BTN_CENTER = '{u: 1'b0, l: 1'b0, d: 1'b0, r: 1'b0, c: 1'b1};
    localparam btn_t BTN_LEFT   = '{u: 1'b0, l: 1'b1, d: 1'b0, r: 1'b0, c: 1'b0};

    logic        clk;
    logic        rst_n;
    btn_t        btn;
    logic [7:0]  sw;
    logic [7:0]  led;
    logic        uart_rxd;
    logic        uart_txd;

    // Random source and register models
    logic [31:0] lfsr_state;
    logic [7:0]  led_expect;
    logic [7:0]  scratch_expect;

    fpga_core uut (
        .clk      (clk),
        .rst_n    (rst_n),
        .btn      (btn),
        .sw       (sw),
        .led      (led),
        .uart_rxd (uart_rxd),
        .uart_txd (uart_txd)
    );

    // Assertions on the shared APB bus inside the core
    bind fpga_core fpga_core_checker checker_inst (
        .clk    (clk),
        .rst_n  (rst_n),
        .s_req  (regs_req),
        .s_rsp  (regs_rsp),
        .m0_req (bridge_req),
        .m0_rsp (bridge_rsp),
        .led    (led)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Galois LFSR, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 32'h8020_0003;
        end
        return state >> 1;
    endfunction

    // One LFSR step per bit, bits land at the bottom
    task automatic rand_bits(input int count, output logic [7:0] value);
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value      = {value[6:0], lfsr_state[0]};
        end
    endtask

    task automatic stop_run();
        $display("Test failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic report_failure(input string what);
        $display("ERROR at %0t: %s", $time, what);
        stop_run();
    endtask

    task automatic check_byte(input string name, input logic [7:0] actual,
                              input logic [7:0] expected);
        if (actual !== expected) begin
            $display("MISMATCH at %0t: %s got 8'h%02h expected 8'h%02h",
                     $time, name, actual, expected);
            stop_run();
        end
    endtask

    task automatic check_btn(input string name, input btn_t actual, input btn_t expected);
        if (actual !== expected) begin
            $display("MISMATCH at %0t: %s got 5'b%05b expected 5'b%05b",
                     $time, name, actual, expected);
            stop_run();
        end
    endtask

    // Host side 8N1 transmit, LSB first
    task automatic uart_send(input logic [7:0] value);
        logic [9:0] frame;
        frame = {1'b1, value, 1'b0};
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            uart_rxd <= frame[0];
            frame = {1'b1, frame[9:1]};
            repeat (UART_DIV - 1) @(posedge clk);
        end
    endtask

    // Host side 8N1 receive, sampled mid-bit on falling clock edges
    task automatic uart_recv(output logic [7:0] value);
        int waited;
        waited = 0;
        value  = '0;
        @(negedge clk);
        while (uart_txd !== 1'b0) begin
            if (waited >= RX_TIMEOUT) begin
                report_failure("timeout waiting for a UART start bit from the DUT");
            end
            @(negedge clk);
            waited++;
        end
        repeat (UART_DIV / 2) @(negedge clk);
        if (uart_txd !== 1'b0) begin
            report_failure("UART start bit from the DUT ended early");
        end
        for (int i = 0; i < 8; i++) begin
            repeat (UART_DIV) @(negedge clk);
            value = {uart_txd, value[7:1]};
        end
        repeat (UART_DIV) @(negedge clk);
        if (uart_txd !== 1'b1) begin
            report_failure("UART stop bit from the DUT missing");
        end
    endtask

    task automatic expect_line_idle(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            @(negedge clk);
            if (uart_txd !== 1'b1) begin
                report_failure("UART line left idle, unexpected reply byte");
            end
        end
    endtask

    // Fixed by the debounce latency bound
    task automatic settle_inputs();
        repeat (SETTLE_CYCLES) @(posedge clk);
    endtask

    task automatic wait_led(input logic [7:0] expected, input string name);
        int waited;
        waited = 0;
        @(negedge clk);
        while (led !== expected && waited < LED_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        check_byte(name, led, expected);
    endtask

    // Reply collection runs alongside the command bytes
    task automatic write_register(input logic [7:0] addr, input logic [7:0] value,
                                  output logic [7:0] status);
        fork
            begin
                uart_send(CMD_WRITE);
                uart_send(addr);
                uart_send(value);
            end
            uart_recv(status);
        join
    endtask

    task automatic read_register(input logic [7:0] addr, output logic [7:0] status);
        fork
            begin
                uart_send(CMD_READ);
                uart_send(addr);
            end
            uart_recv(status);
        join
    endtask

    task automatic reset_state_idle();
        @(negedge clk);
        check_byte("led after reset", led, 8'h00);
        expect_line_idle(4 * UART_DIV);
    endtask

    task automatic led_scratch_access();
        logic [7:0] status;
        logic [7:0] value;
        logic [7:0] data;
        rand_bits(8, value);
        write_register(REG_LED, value, status);
        check_byte("status of REG_LED write", status, RSP_OK);
        wait_led(value, "led after UART write");
        led_expect = value;
        read_register(REG_LED, status);
        check_byte("status of REG_LED read", status, RSP_OK);
        uart_recv(data);
        check_byte("REG_LED data", data, value);
        // Scratch round trip
        rand_bits(8, value);
        write_register(REG_SCRATCH, value, status);
        check_byte("status of REG_SCRATCH write", status, RSP_OK);
        read_register(REG_SCRATCH, status);
        check_byte("status of REG_SCRATCH read", status, RSP_OK);
        uart_recv(data);
        check_byte("REG_SCRATCH data", data, value);
        scratch_expect = value;
    endtask

    task automatic switch_button_readback();
        logic [7:0] status;
        logic [7:0] value;
        logic [7:0] data;
        logic [7:0] bits;
        btn_t       pattern;
        btn_t       got;
        rand_bits(8, value);
        @(posedge clk);
        sw <= value;
        settle_inputs();
        read_register(REG_SW, status);
        check_byte("status of REG_SW read", status, RSP_OK);
        uart_recv(data);
        check_byte("REG_SW data", data, value);
        // Buttons with no action, at least one held
        rand_bits(3, bits);
        if (bits[2:0] == 3'b000) begin
            bits[0] = 1'b1;
        end
        pattern = '{u: bits[2], l: 1'b0, d: bits[1], r: bits[0], c: 1'b0};
        @(posedge clk);
        btn <= pattern;
        settle_inputs();
        read_register(REG_BTN, status);
        check_byte("status of REG_BTN read", status, RSP_OK);
        uart_recv(data);
        check_byte("REG_BTN upper bits", {5'b00000, data[7:5]}, 8'h00);
        got = data[4:0];
        check_btn("REG_BTN data", got, pattern);
        @(posedge clk);
        btn <= '0;
        settle_inputs();
    endtask

    task automatic button_led_actions();
        logic [7:0] value;
        // Nonzero and different from the current LEDs
        rand_bits(8, value);
        value[0] = 1'b1;
        if (value == led_expect) begin
            value[7] = ~value[7];
        end
        @(posedge clk);
        sw <= value;
        settle_inputs();
        // Center copies the switches
        @(posedge clk);
        btn <= BTN_CENTER;
        wait_led(value, "led after center press");
        @(posedge clk);
        btn <= '0;
        settle_inputs();
        // Left clears
        @(posedge clk);
        btn <= BTN_LEFT;
        wait_led(8'h00, "led after left press");
        led_expect = 8'h00;
        @(posedge clk);
        btn <= '0;
        settle_inputs();
    endtask

    task automatic error_replies();
        logic [7:0] status;
        logic [7:0] value;
        rand_bits(8, value);
        // Read only register
        write_register(REG_SW, value, status);
        check_byte("status of REG_SW write", status, RSP_ERR);
        expect_line_idle(20 * UART_DIV);
        // Unmapped address
        write_register(8'd9, value, status);
        check_byte("status of write to address 9", status, RSP_ERR);
        expect_line_idle(20 * UART_DIV);
        read_register(8'd9, status);
        check_byte("status of read from address 9", status, RSP_ERR);
        expect_line_idle(20 * UART_DIV);
        // Unknown command, bridge stays silent
        uart_send(CMD_UNKNOWN);
        expect_line_idle(30 * UART_DIV);
        // and still takes the next command
        read_register(REG_SCRATCH, status);
        check_byte("status of REG_SCRATCH read", status, RSP_OK);
        uart_recv(value);
        check_byte("REG_SCRATCH data", value, scratch_expect);
    endtask

    task automatic concurrent_masters();
        logic [7:0] status;
        logic [7:0] sw_value;
        logic [7:0] value;
        logic [7:0] data;
        rand_bits(8, sw_value);
        sw_value[0] = 1'b1;
        if (sw_value == led_expect) begin
            sw_value[7] = ~sw_value[7];
        end
        @(posedge clk);
        sw <= sw_value;
        settle_inputs();
        rand_bits(8, value);
        // Debounced center edge lands near the bridge APB setup
        fork
            begin
                uart_send(CMD_WRITE);
                uart_send(REG_SCRATCH);
                uart_send(value);
            end
            uart_recv(status);
            begin
                repeat (29 * UART_DIV + UART_DIV / 2 - 12) @(posedge clk);
                btn <= BTN_CENTER;
            end
        join
        check_byte("status of REG_SCRATCH write", status, RSP_OK);
        wait_led(sw_value, "led after center press during UART write");
        led_expect = sw_value;
        @(posedge clk);
        btn <= '0;
        settle_inputs();
        read_register(REG_SCRATCH, status);
        check_byte("status of REG_SCRATCH read", status, RSP_OK);
        uart_recv(data);
        check_byte("REG_SCRATCH data", data, value);
        scratch_expect = value;
    endtask

    initial begin
        clk            = 1'b0;
        rst_n          = 1'b1;
        btn            = '0;
        sw             = '0;
        uart_rxd       = 1'b1;
        lfsr_state     = 32'h4db8;
        led_expect     = '0;
        scratch_expect = '0;
        @(posedge clk);
        rst_n <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        reset_state_idle();
        led_scratch_access();
        switch_button_readback();
        button_led_actions();
        error_replies();
        concurrent_masters();
        $display("Test passed");
        $finish;
    end

    // Upper bound on the whole run
    initial begin
        for (int i = 0; i < WATCHDOG_CYCLES; i++) begin
            @(posedge clk);
        end
        report_failure("watchdog expired before the tests finished");
    end

endmodule

`default_nettype wire
